// ==== pc_bus_pkg.sv ====
package pc_bus_pkg;

	localparam int addr_w = 20;
	localparam int data_w = 8;
	localparam int io_port_w = 16;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [io_port_w-1:0] io_port_t;

	// parallel port data register
	localparam io_port_t lpt_data_port = 16'h0378;

	// legacy selects live below 0x100, one per 32-port block
	localparam int legacy_sel_count = 5;

	// index taken from address bits 7..5
	typedef enum logic [2:0] {
		sel_dma = 3'd0,
		sel_pic = 3'd1,
		sel_pit = 3'd2,
		sel_ppi = 3'd3,
		sel_dma_page = 3'd4
	} legacy_sel_e;

endpackage

// ==== ems_pkg.sv ====
package ems_pkg;

	localparam int ems_pages = 4;
	localparam int ems_page_w = 6;
	localparam int ems_sel_w = $clog2(ems_pages);

	// offset inside one 16 KiB page
	localparam int ems_offset_w = 14;

	// flag, page number, page offset
	localparam int ram_addr_w = 1 + ems_page_w + ems_offset_w;

	typedef logic [ems_page_w-1:0] ems_page_t;
	typedef logic [ram_addr_w-1:0] ram_addr_t;

	// upper address nibble of the page frame
	typedef enum logic [3:0] {
		frame_seg_a = 4'hA,
		frame_seg_c = 4'hC,
		frame_seg_d = 4'hD
	} ems_frame_seg_e;

endpackage

// ==== cpu_bus_if.sv ====
`timescale 1ns/1ps

interface cpu_bus_if;

	pc_bus_pkg::addr_t address;
	pc_bus_pkg::data_t data_in;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic address_enable_n;

	modport decoder (
		input address,
		input data_in,
		input io_read_n,
		input io_write_n,
		input address_enable_n
	);

	modport ems (
		input address,
		input data_in,
		input io_read_n,
		input io_write_n,
		input address_enable_n
	);

	// read mux only looks at strobes, selects come in as ports
	modport mux (
		input io_read_n,
		input io_write_n,
		input memory_read_n,
		input address_enable_n
	);

endinterface

// ==== io_port_decoder.sv ====
`timescale 1ns/1ps

module io_port_decoder (
	input  logic clock,
	input  logic reset,
	cpu_bus_if.decoder bus,
	output logic [pc_bus_pkg::legacy_sel_count-1:0] legacy_cs_n_o,
	output logic lpt_cs_o,
	output pc_bus_pkg::data_t lpt_data_o
);
	import pc_bus_pkg::*;

	logic io_request;
	logic low_io_space;
	data_t lpt_data;

	assign io_request = ~bus.io_read_n | ~bus.io_write_n;

	// ports 0x000-0x0ff only, dma cycles have aen high
	assign low_io_space = io_request & ~bus.address_enable_n & (bus.address[9:8] == 2'b00);

	always_comb begin
		legacy_cs_n_o = '1;
		for (int i = 0; i < legacy_sel_count; i++) begin
			if (low_io_space && bus.address[7:5] == 3'(i)) begin
				legacy_cs_n_o[i] = 1'b0;
			end
		end
	end

	// full 16-bit match for the lpt data port
	assign lpt_cs_o = io_request & ~bus.address_enable_n &
		(bus.address[io_port_w-1:0] == lpt_data_port);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data <= 8'hff;
		end else if (lpt_cs_o && !bus.io_write_n) begin
			lpt_data <= bus.data_in;
		end
	end

	assign lpt_data_o = lpt_data;

	a_legacy_cs_onehot: assert property (
		@(posedge clock) disable iff (reset)
		$onehot0(~legacy_cs_n_o)
	) else $error("more than one legacy chip select active");

endmodule

// ==== ems_mapper.sv ====
`timescale 1ns/1ps

module ems_mapper #(
	parameter pc_bus_pkg::io_port_t ems_port_base = 16'h0260
) (
	input  logic clock,
	input  logic reset,
	cpu_bus_if.ems bus,
	input  logic ems_enabled_i,
	input  logic [1:0] frame_sel_i,
	output logic ems_cs_o,
	output pc_bus_pkg::data_t ems_read_data_o,
	output ems_pkg::ram_addr_t ram_addr_o
);
	import pc_bus_pkg::*;
	import ems_pkg::*;

	logic io_request;
	logic mem_access;
	io_port_t io_offset;
	logic [ems_sel_w-1:0] access_page;
	logic page_write;

	// write pipeline stage
	logic write_pending;
	logic [ems_sel_w-1:0] write_page;
	ems_page_t write_map;
	logic write_enable_bit;

	ems_page_t page_map [ems_pages];
	logic [ems_pages-1:0] page_enabled;

	ems_frame_seg_e frame_seg;
	logic [ems_sel_w-1:0] hit_page;
	logic frame_hit;

	assign io_request = ~bus.io_read_n | ~bus.io_write_n;
	assign mem_access = bus.io_read_n & bus.io_write_n;

	// offset from the base, so unaligned bases work too
	assign io_offset = bus.address[io_port_w-1:0] - ems_port_base;
	assign access_page = io_offset[ems_sel_w-1:0];

	assign ems_cs_o = io_request & ~bus.address_enable_n & ems_enabled_i &
		(io_offset < io_port_t'(ems_pages));

	// 0x80..0xfe leave the page alone, so they never enter the pipeline
	assign page_write = ems_cs_o & ~bus.io_write_n &
		((bus.data_in == 8'hff) | ~bus.data_in[7]);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			write_pending <= 1'b0;
		end else begin
			write_pending <= page_write;
		end
	end

	always_ff @(posedge clock) begin
		write_page <= access_page;
		if (bus.data_in == 8'hff) begin
			write_map <= '1;
			write_enable_bit <= 1'b0;
		end else begin
			write_map <= bus.data_in[ems_page_w-1:0];
			write_enable_bit <= 1'b1;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			page_enabled <= '0;
		end else if (write_pending) begin
			page_enabled[write_page] <= write_enable_bit;
		end
	end

	always_ff @(posedge clock) begin
		if (write_pending) begin
			page_map[write_page] <= write_map;
		end
	end

	// unmapped pages read back as 0xff
	assign ems_read_data_o = page_enabled[access_page] ? data_t'(page_map[access_page]) : 8'hff;

	always_comb begin
		case (frame_sel_i)
			2'd0: frame_seg = frame_seg_a;
			2'd1: frame_seg = frame_seg_c;
			default: frame_seg = frame_seg_d;
		endcase
	end

	assign frame_hit = mem_access && (bus.address[addr_w-1:addr_w-4] == frame_seg);
	assign hit_page = bus.address[ems_offset_w+ems_sel_w-1:ems_offset_w];

	always_comb begin
		if (frame_hit && page_enabled[hit_page]) begin
			ram_addr_o = {1'b1, page_map[hit_page], bus.address[ems_offset_w-1:0]};
		end else begin
			ram_addr_o = {1'b0, bus.address};
		end
	end

	// a write sampled during reset never reaches the page registers
	a_no_commit_in_reset: assert property (
		@(posedge clock)
		reset |=> (page_enabled == '0)
	) else $error("ems page enabled right after reset");

endmodule

// ==== read_data_mux.sv ====
`timescale 1ns/1ps

module read_data_mux (
	input  logic clock,
	input  logic reset,
	cpu_bus_if.mux bus,
	input  logic interrupt_acknowledge_n_i,
	input  logic [pc_bus_pkg::legacy_sel_count-1:0] legacy_cs_n_i,
	input  logic lpt_cs_i,
	input  pc_bus_pkg::data_t lpt_data_i,
	input  logic ems_cs_i,
	input  pc_bus_pkg::data_t ems_read_data_i,
	input  pc_bus_pkg::data_t pic_data_i,
	input  pc_bus_pkg::data_t pit_data_i,
	input  pc_bus_pkg::data_t ppi_data_i,
	input  pc_bus_pkg::data_t ram_data_i,
	output pc_bus_pkg::data_t data_bus_out_o,
	output logic from_chipset_o
);
	import pc_bus_pkg::*;

	logic io_read;
	logic ram_read;
	data_t next_data;
	logic next_valid;

	assign io_read = ~bus.io_read_n;

	// any memory read cycle owned by the cpu
	assign ram_read = ~bus.memory_read_n & bus.io_read_n & bus.io_write_n &
		~bus.address_enable_n;

	always_comb begin
		next_valid = 1'b1;
		next_data = '0;
		if (!interrupt_acknowledge_n_i) begin
			// vector byte comes from the pic
			next_data = pic_data_i;
		end else if (io_read && !legacy_cs_n_i[sel_pic]) begin
			next_data = pic_data_i;
		end else if (io_read && !legacy_cs_n_i[sel_pit]) begin
			next_data = pit_data_i;
		end else if (io_read && !legacy_cs_n_i[sel_ppi]) begin
			next_data = ppi_data_i;
		end else if (ram_read) begin
			next_data = ram_data_i;
		end else if (io_read && ems_cs_i) begin
			next_data = ems_read_data_i;
		end else if (io_read && lpt_cs_i) begin
			next_data = lpt_data_i;
		end else begin
			next_valid = 1'b0;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_bus_out_o <= '0;
			from_chipset_o <= 1'b0;
		end else begin
			data_bus_out_o <= next_data;
			from_chipset_o <= next_valid;
		end
	end

	a_idle_bus_released: assert property (
		@(posedge clock) disable iff (reset)
		!next_valid |=> (!from_chipset_o && data_bus_out_o == '0)
	) else $error("chipset drives data bus with no source selected");

endmodule

// ==== pc_peripherals.sv ====
`timescale 1ns/1ps

module pc_peripherals #(
	parameter pc_bus_pkg::io_port_t ems_port_base = 16'h0260
) (
	input  logic clock,
	input  logic reset,
	input  pc_bus_pkg::addr_t address_i,
	input  pc_bus_pkg::data_t data_i,
	input  logic io_read_n_i,
	input  logic io_write_n_i,
	input  logic memory_read_n_i,
	input  logic address_enable_n_i,
	input  logic interrupt_acknowledge_n_i,
	input  logic ems_enabled_i,
	input  logic [1:0] ems_frame_sel_i,
	input  pc_bus_pkg::data_t pic_data_i,
	input  pc_bus_pkg::data_t pit_data_i,
	input  pc_bus_pkg::data_t ppi_data_i,
	input  pc_bus_pkg::data_t ram_data_i,
	output logic dma_cs_n_o,
	output logic pic_cs_n_o,
	output logic pit_cs_n_o,
	output logic ppi_cs_n_o,
	output logic dma_page_cs_n_o,
	output ems_pkg::ram_addr_t ram_addr_o,
	output pc_bus_pkg::data_t data_bus_out_o,
	output logic from_chipset_o
);
	import pc_bus_pkg::*;

	logic [legacy_sel_count-1:0] legacy_cs_n;
	logic lpt_cs;
	data_t lpt_data;
	logic ems_cs;
	data_t ems_read_data;

	cpu_bus_if bus ();

	assign bus.address = address_i;
	assign bus.data_in = data_i;
	assign bus.io_read_n = io_read_n_i;
	assign bus.io_write_n = io_write_n_i;
	assign bus.memory_read_n = memory_read_n_i;
	assign bus.address_enable_n = address_enable_n_i;

	io_port_decoder u_io_port_decoder (
		.clock(clock),
		.reset(reset),
		.bus(bus.decoder),
		.legacy_cs_n_o(legacy_cs_n),
		.lpt_cs_o(lpt_cs),
		.lpt_data_o(lpt_data)
	);

	ems_mapper #(
		.ems_port_base(ems_port_base)
	) u_ems_mapper (
		.clock(clock),
		.reset(reset),
		.bus(bus.ems),
		.ems_enabled_i(ems_enabled_i),
		.frame_sel_i(ems_frame_sel_i),
		.ems_cs_o(ems_cs),
		.ems_read_data_o(ems_read_data),
		.ram_addr_o(ram_addr_o)
	);

	read_data_mux u_read_data_mux (
		.clock(clock),
		.reset(reset),
		.bus(bus.mux),
		.interrupt_acknowledge_n_i(interrupt_acknowledge_n_i),
		.legacy_cs_n_i(legacy_cs_n),
		.lpt_cs_i(lpt_cs),
		.lpt_data_i(lpt_data),
		.ems_cs_i(ems_cs),
		.ems_read_data_i(ems_read_data),
		.pic_data_i(pic_data_i),
		.pit_data_i(pit_data_i),
		.ppi_data_i(ppi_data_i),
		.ram_data_i(ram_data_i),
		.data_bus_out_o(data_bus_out_o),
		.from_chipset_o(from_chipset_o)
	);

	// external cores still need their selects
	assign dma_cs_n_o = legacy_cs_n[sel_dma];
	assign pic_cs_n_o = legacy_cs_n[sel_pic];
	assign pit_cs_n_o = legacy_cs_n[sel_pit];
	assign ppi_cs_n_o = legacy_cs_n[sel_ppi];
	assign dma_page_cs_n_o = legacy_cs_n[sel_dma_page];

endmodule

// ==== tb_pc_peripherals.sv ====
`timescale 1ns/1ps

module tb_pc_peripherals;
	import pc_bus_pkg::*;
	import ems_pkg::*;

	localparam int max_patterns = 64;

	logic clock;
	logic reset;
	addr_t address_i;
	data_t data_i;
	logic io_read_n_i;
	logic io_write_n_i;
	logic memory_read_n_i;
	logic address_enable_n_i;
	logic interrupt_acknowledge_n_i;
	logic ems_enabled_i;
	logic [1:0] ems_frame_sel_i;
	data_t pic_data_i;
	data_t pit_data_i;
	data_t ppi_data_i;
	data_t ram_data_i;
	logic dma_cs_n_o;
	logic pic_cs_n_o;
	logic pit_cs_n_o;
	logic ppi_cs_n_o;
	logic dma_page_cs_n_o;
	ram_addr_t ram_addr_o;
	data_t data_bus_out_o;
	logic from_chipset_o;

	// one entry per line of the pattern file
	string pat_name [max_patterns];
	addr_t pat_addr [max_patterns];
	data_t pat_data [max_patterns];
	logic pat_ior_n [max_patterns];
	logic pat_iow_n [max_patterns];
	logic pat_memr_n [max_patterns];
	logic pat_aen_n [max_patterns];
	logic pat_inta_n [max_patterns];
	logic pat_ems_en [max_patterns];
	logic [1:0] pat_frame [max_patterns];
	logic [4:0] pat_cs_n [max_patterns];
	ram_addr_t pat_ram_addr [max_patterns];
	int pat_src [max_patterns];
	data_t pat_exp [max_patterns];

	int pattern_count = 0;
	logic patterns_loaded = 1'b0;
	int tests_failed = 0;
	int test_errors = 0;
	int load_errors = 0;
	data_t pic_val;
	data_t pit_val;
	data_t ppi_val;
	data_t ram_val;

	pc_peripherals u_pc_peripherals (
		.clock(clock),
		.reset(reset),
		.address_i(address_i),
		.data_i(data_i),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.memory_read_n_i(memory_read_n_i),
		.address_enable_n_i(address_enable_n_i),
		.interrupt_acknowledge_n_i(interrupt_acknowledge_n_i),
		.ems_enabled_i(ems_enabled_i),
		.ems_frame_sel_i(ems_frame_sel_i),
		.pic_data_i(pic_data_i),
		.pit_data_i(pit_data_i),
		.ppi_data_i(ppi_data_i),
		.ram_data_i(ram_data_i),
		.dma_cs_n_o(dma_cs_n_o),
		.pic_cs_n_o(pic_cs_n_o),
		.pit_cs_n_o(pit_cs_n_o),
		.ppi_cs_n_o(ppi_cs_n_o),
		.dma_page_cs_n_o(dma_page_cs_n_o),
		.ram_addr_o(ram_addr_o),
		.data_bus_out_o(data_bus_out_o),
		.from_chipset_o(from_chipset_o)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			test_errors++;
		end
	endtask

	// src code from the pattern file picks the source byte
	function automatic data_t expected_read(input int src, input data_t literal);
		case (src)
			1: return pic_val;
			2: return pit_val;
			3: return ppi_val;
			4: return ram_val;
			5: return literal;
			default: return 8'h00;
		endcase
	endfunction

	task automatic load_patterns();
		int fd;
		int r;
		string line;
		string name;
		addr_t a;
		data_t d;
		logic ior;
		logic iow;
		logic memr;
		logic aen;
		logic inta;
		logic ems;
		int frame;
		logic [4:0] cs;
		ram_addr_t ra;
		int src;
		data_t ex;
		fd = $fopen("bus_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open bus_patterns.txt");
			load_errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			r = $sscanf(line, "%s %h %h %b %b %b %b %b %b %d %b %h %d %h", name, a, d,
				ior, iow, memr, aen, inta, ems, frame, cs, ra, src, ex);
			if (r != 14 || pattern_count >= max_patterns) begin
				$display("a pattern line could not be read and was skipped");
				load_errors++;
				continue;
			end
			pat_name[pattern_count] = name;
			pat_addr[pattern_count] = a;
			pat_data[pattern_count] = d;
			pat_ior_n[pattern_count] = ior;
			pat_iow_n[pattern_count] = iow;
			pat_memr_n[pattern_count] = memr;
			pat_aen_n[pattern_count] = aen;
			pat_inta_n[pattern_count] = inta;
			pat_ems_en[pattern_count] = ems;
			pat_frame[pattern_count] = 2'(frame);
			pat_cs_n[pattern_count] = cs;
			pat_ram_addr[pattern_count] = ra;
			pat_src[pattern_count] = src;
			pat_exp[pattern_count] = ex;
			pattern_count++;
		end
		$fclose(fd);
	endtask

	task automatic drive_idle();
		address_i <= '0;
		data_i <= '0;
		io_read_n_i <= 1'b1;
		io_write_n_i <= 1'b1;
		memory_read_n_i <= 1'b1;
		address_enable_n_i <= 1'b0;
		interrupt_acknowledge_n_i <= 1'b1;
	endtask

	task automatic run_pattern(input int i);
		data_t exp_bus;
		logic [4:0] cs_n;
		test_errors = 0;
		@(posedge clock);
		address_i <= pat_addr[i];
		data_i <= pat_data[i];
		io_read_n_i <= pat_ior_n[i];
		io_write_n_i <= pat_iow_n[i];
		memory_read_n_i <= pat_memr_n[i];
		address_enable_n_i <= pat_aen_n[i];
		interrupt_acknowledge_n_i <= pat_inta_n[i];
		ems_enabled_i <= pat_ems_en[i];
		ems_frame_sel_i <= pat_frame[i];
		// selects and translation settle within the cycle
		@(negedge clock);
		cs_n = {dma_page_cs_n_o, ppi_cs_n_o, pit_cs_n_o, pic_cs_n_o, dma_cs_n_o};
		check_value({pat_name[i], " cs_n"}, 32'(pat_cs_n[i]), 32'(cs_n));
		check_value({pat_name[i], " ram_addr"}, 32'(pat_ram_addr[i]), 32'(ram_addr_o));
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		exp_bus = expected_read(pat_src[i], pat_exp[i]);
		check_value({pat_name[i], " data_bus_out"}, 32'(exp_bus), 32'(data_bus_out_o));
		check_value({pat_name[i], " from_chipset"}, 32'(pat_src[i] != 0),
			32'(from_chipset_o));
		// page registers commit on the second edge after a write
		repeat (2) @(posedge clock);
		if (test_errors == 0) begin
			$display("test %s ok", pat_name[i]);
		end else begin
			$display("test %s failed", pat_name[i]);
			tests_failed++;
		end
	endtask

	initial begin
		int seed;
		clock = 1'b0;
		reset = 1'b1;
		address_i = '0;
		data_i = '0;
		io_read_n_i = 1'b1;
		io_write_n_i = 1'b1;
		memory_read_n_i = 1'b1;
		address_enable_n_i = 1'b0;
		interrupt_acknowledge_n_i = 1'b1;
		ems_enabled_i = 1'b1;
		ems_frame_sel_i = 2'd0;
		seed = $urandom(32'h23f21252);
		// distinct nonzero bytes so every source can be told apart
		do begin
			pic_val = 8'($urandom);
			pit_val = 8'($urandom);
			ppi_val = 8'($urandom);
			ram_val = 8'($urandom);
		end while (pic_val == 8'h00 || pit_val == 8'h00 || ppi_val == 8'h00 ||
			ram_val == 8'h00 || pic_val == pit_val || pic_val == ppi_val ||
			pic_val == ram_val || pit_val == ppi_val || pit_val == ram_val ||
			ppi_val == ram_val);
		pic_data_i = pic_val;
		pit_data_i = pit_val;
		ppi_data_i = ppi_val;
		ram_data_i = ram_val;
		load_patterns();
		patterns_loaded = 1'b1;
		if (pattern_count == 0) begin
			$display("no bus patterns were loaded, nothing was tested");
			load_errors++;
		end
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < pattern_count; i++) begin
			run_pattern(i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d unreadable lines", pattern_count,
			pattern_count - tests_failed, tests_failed, load_errors);
		if (tests_failed == 0 && load_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// watchdog scaled to the number of patterns
	initial begin
		wait (patterns_loaded);
		repeat (pattern_count * 20 + 100) @(posedge clock);
		$display("timeout, the pattern run did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== bus_patterns.txt ====
# name addr data ior_n iow_n memr_n aen_n inta_n ems_en frame cs_n(dma_page..dma) ram_addr src exp
# src: 0 idle bus, 1 pic, 2 pit, 3 ppi, 4 ram, 5 byte from the exp column
lpt_read_after_reset 00378 00 0 1 1 0 1 1 0 11111 000378 5 ff
dma_read 00000 00 0 1 1 0 1 1 0 11110 000000 0 00
pic_read 00020 00 0 1 1 0 1 1 0 11101 000020 1 00
pit_write 00040 5a 1 0 1 0 1 1 0 11011 000040 0 00
pit_read 00043 00 0 1 1 0 1 1 0 11011 000043 2 00
ppi_read 00061 00 0 1 1 0 1 1 0 10111 000061 3 00
dma_page_write 00081 12 1 0 1 0 1 1 0 01111 000081 0 00
aen_high_read 00020 00 0 1 1 1 1 1 0 11111 000020 0 00
no_io_strobe 00040 00 1 1 1 0 1 1 0 11111 000040 0 00
lpt_write 00378 a5 1 0 1 0 1 1 0 11111 000378 0 00
lpt_read 00378 00 0 1 1 0 1 1 0 11111 000378 5 a5
ems_read_unmapped 00260 00 0 1 1 0 1 1 0 11111 000260 5 ff
ems_write_page0 00260 05 1 0 1 0 1 1 0 11111 000260 0 00
ems_read_page0 00260 00 0 1 1 0 1 1 0 11111 000260 5 05
ems_write_page1 00261 3f 1 0 1 0 1 1 0 11111 000261 0 00
ems_read_page1 00261 00 0 1 1 0 1 1 0 11111 000261 5 3f
ems_write_reserved 00261 80 1 0 1 0 1 1 0 11111 000261 0 00
ems_write_reserved_fe 00261 fe 1 0 1 0 1 1 0 11111 000261 0 00
ems_read_page1_kept 00261 00 0 1 1 0 1 1 0 11111 000261 5 3f
mem_frame_a_page0 a0123 00 1 1 0 0 1 1 0 11111 114123 4 00
mem_frame_c_page1 c4567 00 1 1 0 0 1 1 1 11111 1fc567 4 00
mem_frame_d_page0 d0010 00 1 1 0 0 1 1 2 11111 114010 4 00
mem_frame_d_sel3 d7fff 00 1 1 0 0 1 1 3 11111 1fffff 4 00
mem_outside_frame c0123 00 1 1 0 0 1 1 0 11111 0c0123 4 00
mem_page2_disabled a8000 00 1 1 0 0 1 1 0 11111 0a8000 4 00
ems_disable_page1 00261 ff 1 0 1 0 1 1 0 11111 000261 0 00
ems_read_page1_off 00261 00 0 1 1 0 1 1 0 11111 000261 5 ff
mem_page1_disabled a4000 00 1 1 0 0 1 1 0 11111 0a4000 4 00
inta_over_ppi 00060 00 0 1 1 0 0 1 0 10111 000060 1 00
ems_off_write 00262 07 1 0 1 0 1 0 0 11111 000262 0 00
ems_off_read 00262 00 0 1 1 0 1 0 0 11111 000262 0 00
ems_read_page2 00262 00 0 1 1 0 1 1 0 11111 000262 5 ff
idle_bus 00000 00 1 1 1 0 1 1 0 11111 000000 0 00

// ==== files.f ====
pc_bus_pkg.sv
ems_pkg.sv
cpu_bus_if.sv
io_port_decoder.sv
ems_mapper.sv
read_data_mux.sv
pc_peripherals.sv
tb_pc_peripherals.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_pc_peripherals \
	-f files.f \
	-o sim_tb_pc_peripherals

./obj_dir/sim_tb_pc_peripherals | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
